// File: src.f
dcache_pkg.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_lookup.sv
dcache_bus_seq.sv
dcache_top.sv
tb_clk_gen.sv
tb_bus_mem.sv
tb_dcache_assert.sv
tb_dcache.sv

// File: tb_dcache.sv
// Data cache testbench with random reads and writes checked against a memory and line-state model.
module tb_dcache;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int txn_count      = 200;
	localparam int timeout_cycles = (txn_count + 8) * 200;

	logic        clk;
	logic        arst_n;
	logic        rd_req;
	logic        wr_req;
	logic [31:0] addr;
	logic [31:0] wr_data;
	logic        rw_wait;
	logic [31:0] rd_data;
	logic        bus_req;
	logic        bus_ack;
	logic        bus_rd;
	logic        bus_wr;
	logic        bus_ready;
	logic [31:0] bus_addr;
	logic [31:0] bus_rdata;
	logic [31:0] bus_wdata;
	logic [1:0]  ack_dly;
	logic [1:0]  rdy_dly;
	int          rd_count;
	int          wr_count;
	logic [31:0] last_wr_addr;
	logic [31:0] last_wr_data;

	logic [31:0] lfsr;
	logic [31:0] ref_mem [1024];
	logic [15:0] line_valid;
	logic [21:0] line_tag [16];
	int          errors = 0;
	int          cycles = 0;
	int          done_txns = 0;

	tb_clk_gen u_clk (.*);
	dcache_top u_dut (.*);
	tb_bus_mem u_mem (.*);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken.
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] make_addr(input logic [1:0] tag, input logic [2:0] idx,
		input logic [3:0] word);
		return {20'b0, tag, 1'b0, idx, word, 2'b00};
	endfunction

	task automatic value_error(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		errors++;
	endtask

	// Holds one request until rw_wait falls, then checks it against the model.
	task automatic run_txn(input logic is_wr, input logic [31:0] a, input logic [31:0] d);
		logic [3:0]  li;
		logic        exp_hit;
		logic [31:0] rnd;
		logic [31:0] got;
		logic [31:0] exp_addr;
		int          rd0;
		int          wr0;
		li = a[9:6];
		exp_hit = line_valid[li] && (line_tag[li] == a[31:10]);
		rd0 = rd_count;
		wr0 = wr_count;
		take_bits(4, rnd);
		ack_dly = rnd[1:0];
		rdy_dly = rnd[3:2];
		rd_req = !is_wr;
		wr_req = is_wr;
		addr = a;
		wr_data = d;
		@(negedge clk);
		if (!is_wr && exp_hit && rw_wait) begin
			$display("Read hit at %h kept rw_wait high in its request cycle", a);
			errors++;
		end
		while (rw_wait) @(negedge clk);
		got = rd_data;
		@(posedge clk);
		#1;
		rd_req = 1'b0;
		wr_req = 1'b0;
		if (is_wr) begin
			if (wr_count - wr0 != 1) value_error("write_beats", 1, wr_count - wr0);
			if (last_wr_addr != a) value_error("write_addr", a, last_wr_addr);
			if (last_wr_data != d) value_error("write_data", d, last_wr_data);
			if (rd_count != rd0) value_error("write_reads", 0, rd_count - rd0);
			ref_mem[a[11:2]] = d;
		end else begin
			if (got != ref_mem[a[11:2]]) value_error("read_data", ref_mem[a[11:2]], got);
			if (rd_count - rd0 != (exp_hit ? 0 : 16)) begin
				value_error("read_beats", exp_hit ? 0 : 16, rd_count - rd0);
			end else if (!exp_hit) begin
				for (int k = 0; k < 16; k++) begin
					exp_addr = {a[31:6], 4'(k), 2'b00};
					if (u_mem.rd_log[(rd0 + k) % 4096] != exp_addr) begin
						value_error("fill_order", exp_addr, u_mem.rd_log[(rd0 + k) % 4096]);
					end
				end
			end
			line_valid[li] = 1'b1;
			line_tag[li] = a[31:10];
		end
		done_txns++;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > timeout_cycles) begin
			$display("Timeout after %0d cycles with %0d transactions done", cycles, done_txns);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		logic [31:0] r_op;
		logic [31:0] r_addr;
		logic [31:0] r_data;
		rd_req = 1'b0;
		wr_req = 1'b0;
		addr = '0;
		wr_data = '0;
		ack_dly = '0;
		rdy_dly = '0;
		lfsr = 32'hc64d_5699;
		line_valid = '0;
		for (int i = 0; i < 1024; i++) begin
			ref_mem[i] = u_mem.addr_hash({20'b0, 10'(i), 2'b00});
		end
		@(posedge arst_n);
		@(negedge clk);
		if (bus_req || bus_rd || bus_wr) begin
			$display("Bus request or strobe is high while idle after reset");
			errors++;
		end
		@(posedge clk);
		#1;
		// Miss, hit, write hit, write to an absent line, conflict and refill.
		run_txn(1'b0, make_addr(2'd0, 3'd1, 4'd3), '0);
		run_txn(1'b0, make_addr(2'd0, 3'd1, 4'd5), '0);
		run_txn(1'b1, make_addr(2'd0, 3'd1, 4'd5), 32'h1234_5678);
		run_txn(1'b0, make_addr(2'd0, 3'd1, 4'd5), '0);
		run_txn(1'b1, make_addr(2'd1, 3'd2, 4'd9), 32'h0bad_f00d);
		run_txn(1'b0, make_addr(2'd1, 3'd2, 4'd9), '0);
		run_txn(1'b0, make_addr(2'd2, 3'd1, 4'd0), '0);
		run_txn(1'b0, make_addr(2'd0, 3'd1, 4'd5), '0);
		for (int n = 0; n < txn_count; n++) begin
			take_bits(2, r_op);
			take_bits(9, r_addr);
			take_bits(32, r_data);
			run_txn(r_op[1:0] == 2'd0, make_addr(r_addr[8:7], r_addr[6:4], r_addr[3:0]), r_data);
		end
		$display("Finished %0d transactions with %0d check errors and %0d assertion failures",
			done_txns, errors, u_dut.u_assert.fail_count);
		if (errors + u_dut.u_assert.fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: tb_dcache_assert.sv
// Bus and core handshake assertions for the data cache top level.
module tb_dcache_assert (
	input logic        clk,
	input logic        arst_n,
	input logic        rw_wait,
	input logic        bus_req,
	input logic        bus_ack,
	input logic        bus_rd,
	input logic        bus_wr,
	input logic [31:0] bus_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	strobes_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(bus_rd && bus_wr))
		else begin
			$error("bus_rd and bus_wr are high together");
			fail_count++;
		end

	strobes_granted: assert property (@(posedge clk) disable iff (!arst_n)
		(bus_rd || bus_wr) |-> bus_ack)
		else begin
			$error("bus strobe is high without bus_ack");
			fail_count++;
		end

	read_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		bus_rd |-> (bus_addr[1:0] == 2'b00))
		else begin
			$error("bus read address is not word aligned");
			fail_count++;
		end

	wait_has_req: assert property (@(posedge clk) disable iff (!arst_n)
		rw_wait |-> bus_req)
		else begin
			$error("rw_wait is high while bus_req is low");
			fail_count++;
		end

endmodule

bind dcache_top tb_dcache_assert u_assert (
	.clk      (clk),
	.arst_n   (arst_n),
	.rw_wait  (rw_wait),
	.bus_req  (bus_req),
	.bus_ack  (bus_ack),
	.bus_rd   (bus_rd),
	.bus_wr   (bus_wr),
	.bus_addr (bus_addr)
);

// File: tb_bus_mem.sv
// Testbench bus memory of 4 KB with delayed grant and ready, and a log of bus traffic.
module tb_bus_mem (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        bus_req,
	input  logic        bus_rd,
	input  logic        bus_wr,
	input  logic [31:0] bus_addr,
	input  logic [31:0] bus_wdata,
	input  logic [1:0]  ack_dly,
	input  logic [1:0]  rdy_dly,
	output logic        bus_ack,
	output logic        bus_ready,
	output logic [31:0] bus_rdata,
	output int          rd_count,
	output int          wr_count,
	output logic [31:0] last_wr_addr,
	output logic [31:0] last_wr_data
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] mem [1024];
	logic [31:0] rd_log [4096];
	logic [1:0]  ack_cnt;
	logic [1:0]  rdy_cnt;
	logic        next_ack;
	logic        next_rdy;

	// The multiply spreads every address bit over the whole word.
	function automatic logic [31:0] addr_hash(input logic [31:0] a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h3c5a_a5c3;
	endfunction

	initial begin
		for (int i = 0; i < 1024; i++) begin
			mem[i] = addr_hash({20'b0, 10'(i), 2'b00});
		end
		bus_ack = 1'b0;
		bus_ready = 1'b0;
		ack_cnt = '0;
		rdy_cnt = '0;
		rd_count = 0;
		wr_count = 0;
		last_wr_addr = '0;
		last_wr_data = '0;
	end

	assign bus_rdata = mem[bus_addr[11:2]];

	// Everything is sampled at the edge; grant and ready change 1 ns later.
	always @(posedge clk) begin
		next_ack = bus_ack;
		next_rdy = bus_ready;
		if (bus_wr && bus_ready) begin
			mem[bus_addr[11:2]] <= bus_wdata;
			wr_count <= wr_count + 1;
			last_wr_addr <= bus_addr;
			last_wr_data <= bus_wdata;
		end
		if (bus_rd && bus_ready) begin
			rd_log[rd_count % 4096] <= bus_addr;
			rd_count <= rd_count + 1;
		end
		// A finished write or a dropped request ends the grant.
		if (!arst_n || !bus_req || (bus_wr && bus_ready)) begin
			next_ack = 1'b0;
			next_rdy = 1'b0;
			ack_cnt = '0;
			rdy_cnt = '0;
		end else begin
			if (!bus_ack) begin
				if (ack_cnt == ack_dly) begin
					next_ack = 1'b1;
					ack_cnt = '0;
				end else begin
					ack_cnt = ack_cnt + 1'b1;
				end
			end
			if (bus_rd && bus_ready) begin
				next_rdy = 1'b0;
			end else if ((bus_rd || bus_wr) && !bus_ready) begin
				if (rdy_cnt == rdy_dly) begin
					next_rdy = 1'b1;
					rdy_cnt = '0;
				end else begin
					rdy_cnt = rdy_cnt + 1'b1;
				end
			end
		end
		#1;
		bus_ack = next_ack;
		bus_ready = next_rdy;
	end

endmodule

// File: tb_clk_gen.sv
// Testbench clock and reset source with a 4 ns period and reset held low for 10 cycles.
module tb_clk_gen (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reset is released just after an edge, like every other stimulus.
	initial begin
		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		#1 arst_n = 1'b1;
	end

endmodule

// File: dcache_top.sv
// Data cache top level joining lookup, bus sequencer, tag store and data store.
module dcache_top import dcache_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              rd_req,
	input  logic              wr_req,
	input  logic [addr_w-1:0] addr,
	input  logic [addr_w-1:0] wr_data,
	output logic              rw_wait,
	output logic [addr_w-1:0] rd_data,
	output logic              bus_req,
	input  logic              bus_ack,
	output logic [addr_w-1:0] bus_addr,
	input  logic [addr_w-1:0] bus_rdata,
	output logic [addr_w-1:0] bus_wdata,
	output logic              bus_rd,
	output logic              bus_wr,
	input  logic              bus_ready
);

	core_req_t         core_req;
	addr_fields_t      fields;
	req_kind_e         req_kind;
	bus_cmd_t          bus_cmd;
	array_wr_t         array_wr;
	logic              hit;
	logic              fill_start;
	logic              fill_done;
	logic [addr_w-1:0] rd_word;

	assign core_req = '{rd: rd_req, wr: wr_req, addr: addr, wdata: wr_data};

	assign bus_rd    = bus_cmd.rd;
	assign bus_wr    = bus_cmd.wr;
	assign bus_addr  = bus_cmd.addr;
	assign bus_wdata = bus_cmd.wdata;

	dcache_lookup u_lookup (
		.core_req  (core_req),
		.hit       (hit),
		.rd_word   (rd_word),
		.bus_ack   (bus_ack),
		.bus_ready (bus_ready),
		.fields    (fields),
		.req_kind  (req_kind),
		.rw_wait   (rw_wait),
		.rd_data   (rd_data)
	);

	dcache_bus_seq u_bus_seq (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_kind   (req_kind),
		.fields     (fields),
		.wr_data    (core_req.wdata),
		.hit        (hit),
		.bus_ack    (bus_ack),
		.bus_ready  (bus_ready),
		.bus_rdata  (bus_rdata),
		.bus_req    (bus_req),
		.bus_cmd    (bus_cmd),
		.array_wr   (array_wr),
		.fill_start (fill_start),
		.fill_done  (fill_done)
	);

	dcache_tag_store u_tag_store (
		.clk        (clk),
		.arst_n     (arst_n),
		.idx        (fields.idx),
		.tag        (fields.tag),
		.fill_start (fill_start),
		.fill_done  (fill_done),
		.hit        (hit)
	);

	dcache_data_store u_data_store (
		.clk      (clk),
		.idx      (fields.idx),
		.word     (fields.word),
		.array_wr (array_wr),
		.rd_word  (rd_word)
	);

endmodule

// File: dcache_bus_seq.sv
// Bus sequencing stage that runs line fills and write-through and issues array updates.
module dcache_bus_seq import dcache_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  req_kind_e         req_kind,
	input  addr_fields_t      fields,
	input  logic [addr_w-1:0] wr_data,
	input  logic              hit,
	input  logic              bus_ack,
	input  logic              bus_ready,
	input  logic [addr_w-1:0] bus_rdata,
	output logic              bus_req,
	output bus_cmd_t          bus_cmd,
	output array_wr_t         array_wr,
	output logic              fill_start,
	output logic              fill_done
);

	fill_state_e            state;
	logic [word_w-1:0]      fill_pos;
	logic [line_addr_w-1:0] fill_line;

	logic [line_addr_w-1:0] line;
	logic                   restart;
	logic [word_w-1:0]      eff_pos;
	logic                   beat_rd;
	logic                   beat_wr;

	always_comb begin
		line = {fields.tag, fields.idx};
	end

	// A fill in flight for some other line starts over at word 0. The
	// restart is seen in the same cycle, so no stale position reaches the bus.
	always_comb begin
		restart = (state == st_filling) && (line != fill_line);
		eff_pos = restart ? '0 : fill_pos;
	end

	always_comb begin
		bus_req = (req_kind == req_rd_miss) || (req_kind == req_write);
	end

	// Strobes follow the grant; address and data stay at zero otherwise.
	always_comb begin
		bus_cmd = '0;
		if (bus_ack && (req_kind == req_rd_miss)) begin
			bus_cmd.rd   = 1'b1;
			bus_cmd.addr = {fields.tag, fields.idx, eff_pos, {off_w{1'b0}}};
		end else if (bus_ack && (req_kind == req_write)) begin
			bus_cmd.wr    = 1'b1;
			bus_cmd.addr  = fields;
			bus_cmd.wdata = wr_data;
		end
	end

	always_comb begin
		beat_rd = bus_cmd.rd && bus_ready;
		beat_wr = bus_cmd.wr && bus_ready;
	end

	// The line goes invalid with its first new word and valid with its last.
	always_comb begin
		fill_start = beat_rd && (eff_pos == '0);
		fill_done  = beat_rd && (eff_pos == word_w'(line_words - 1));
	end

	// Fill words go in at the fill position. A write touches the array
	// only when the line is present, since writes do not allocate.
	always_comb begin
		array_wr = '0;
		if (beat_rd) begin
			array_wr.en   = 1'b1;
			array_wr.widx = {fields.idx, eff_pos};
			array_wr.data = bus_rdata;
		end else if (beat_wr && hit) begin
			array_wr.en   = 1'b1;
			array_wr.widx = {fields.idx, fields.word};
			array_wr.data = wr_data;
		end
	end

	// Anything other than a read miss on the same line, including a write
	// arriving mid-fill, drops the sequencer back to idle at word 0.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= st_idle;
			fill_pos <= '0;
		end else if (beat_rd) begin
			if (fill_done) begin
				state    <= st_idle;
				fill_pos <= '0;
			end else begin
				state    <= st_filling;
				fill_pos <= eff_pos + 1'b1;
			end
		end else if ((req_kind != req_rd_miss) || restart) begin
			state    <= st_idle;
			fill_pos <= '0;
		end
	end

	// Line address of the fill in flight; compared only while filling.
	always_ff @(posedge clk) begin
		if (beat_rd) begin
			fill_line <= line;
		end
	end

endmodule

// File: dcache_lookup.sv
// Address lookup stage that classifies the core request and answers it with wait and data.
module dcache_lookup import dcache_pkg::*; (
	input  core_req_t         core_req,
	input  logic              hit,
	input  logic [addr_w-1:0] rd_word,
	input  logic              bus_ack,
	input  logic              bus_ready,
	output addr_fields_t      fields,
	output req_kind_e         req_kind,
	output logic              rw_wait,
	output logic [addr_w-1:0] rd_data
);

	logic write_done;

	always_comb begin
		fields = addr_fields_t'(core_req.addr);
	end

	// A write wins over a read when the core raises both.
	always_comb begin
		if (core_req.wr) begin
			req_kind = req_write;
		end else if (core_req.rd) begin
			req_kind = hit ? req_rd_hit : req_rd_miss;
		end else begin
			req_kind = req_none;
		end
	end

	// A write beat completes in the cycle the bus both grants and accepts it.
	always_comb begin
		write_done = bus_ack && bus_ready;
	end

	// A read miss keeps the core waiting until the fill makes it a hit.
	always_comb begin
		case (req_kind)
			req_rd_miss: rw_wait = 1'b1;
			req_write:   rw_wait = !write_done;
			default:     rw_wait = 1'b0;
		endcase
	end

	always_comb begin
		rd_data = rd_word;
	end

endmodule

// File: dcache_data_store.sv
// Data array of 256 words with asynchronous read and one shared write port.
module dcache_data_store import dcache_pkg::*; (
	input  logic              clk,
	input  logic [idx_w-1:0]  idx,
	input  logic [word_w-1:0] word,
	input  array_wr_t         array_wr,
	output logic [addr_w-1:0] rd_word
);

	localparam int depth = line_count * line_words;

	logic [addr_w-1:0] mem [depth];

	// The read port follows the current core address so that a hit
	// can answer in the same cycle.
	always_comb begin
		rd_word = mem[{idx, word}];
	end

	// Fill words and write-through hits share this port; the bus
	// sequencer never raises both in one cycle.
	always_ff @(posedge clk) begin
		if (array_wr.en) begin
			mem[array_wr.widx] <= array_wr.data;
		end
	end

endmodule

// File: dcache_tag_store.sv
// Tag store holding valid bits and tags for every cache line, with hit detection.
module dcache_tag_store import dcache_pkg::*; (
	input  logic             clk,
	input  logic             arst_n,
	input  logic [idx_w-1:0] idx,
	input  logic [tag_w-1:0] tag,
	input  logic             fill_start,
	input  logic             fill_done,
	output logic             hit
);

	logic [line_count-1:0] valid;
	logic [tag_w-1:0]      tags [line_count];

	// A line hits only when it is valid and its stored tag matches the address.
	always_comb begin
		hit = valid[idx] && (tags[idx] == tag);
	end

	// The first fill beat drops the line, the last one brings it back.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
		end else if (fill_done) begin
			valid[idx] <= 1'b1;
		end else if (fill_start) begin
			valid[idx] <= 1'b0;
		end
	end

	// The tag is only meaningful once the valid bit is set, so it is
	// written together with the final word of the fill.
	always_ff @(posedge clk) begin
		if (fill_done) begin
			tags[idx] <= tag;
		end
	end

endmodule

// File: dcache_pkg.sv
// Shared definitions of the level-one data cache for address fields, bundles and state enums.
package dcache_pkg;

	// A direct-mapped cache of 16 lines with 16 words of 32 bits each.
	localparam int addr_w     = 32;
	localparam int line_count = 16;
	localparam int line_words = 16;
	localparam int tag_w      = 22;
	localparam int idx_w      = 4;
	localparam int word_w     = 4;

	// Derived widths for the byte offset, the line address and the flat array index.
	localparam int off_w       = addr_w - tag_w - idx_w - word_w;
	localparam int line_addr_w = tag_w + idx_w;
	localparam int arr_idx_w   = idx_w + word_w;

	// Core address as seen by the cache, most significant field first.
	typedef struct packed {
		logic [tag_w-1:0]  tag;
		logic [idx_w-1:0]  idx;
		logic [word_w-1:0] word;
		logic [off_w-1:0]  byte_off;
	} addr_fields_t;

	// Request held by the core until rw_wait falls.
	typedef struct packed {
		logic              rd;
		logic              wr;
		logic [addr_w-1:0] addr;
		logic [addr_w-1:0] wdata;
	} core_req_t;

	// Strobes, address and write data presented to the bus while it is granted.
	typedef struct packed {
		logic              rd;
		logic              wr;
		logic [addr_w-1:0] addr;
		logic [addr_w-1:0] wdata;
	} bus_cmd_t;

	// Single write port of the data array; widx is {line index, word}.
	typedef struct packed {
		logic                 en;
		logic [arr_idx_w-1:0] widx;
		logic [addr_w-1:0]    data;
	} array_wr_t;

	typedef enum logic {
		st_idle,
		st_filling
	} fill_state_e;

	typedef enum logic [1:0] {
		req_none,
		req_rd_hit,
		req_rd_miss,
		req_write
	} req_kind_e;

endpackage
